// File: design/sui_params.svh
// Sizing macros for the SIMD upstream path, included by the package and the RTL
`ifndef SUI_PARAMS_SVH
`define SUI_PARAMS_SVH

// ----------------------------------------
// SIMD side
// ----------------------------------------

// Execution lanes handed over per message
`define SUI_NUM_LANES       8

// One lane register
`define SUI_LANE_WIDTH      16

// Tag from the SIMD that becomes the out-of-band field of every beat
`define SUI_TAG_WIDTH       8

// ----------------------------------------
// Stack upstream bus
// ----------------------------------------

`define SUI_DATA_WIDTH      32

// Two lanes packed per beat
`define SUI_LANES_PER_BEAT  (`SUI_DATA_WIDTH / `SUI_LANE_WIDTH)

// Four beats per message
`define SUI_NUM_BEATS       (`SUI_NUM_LANES / `SUI_LANES_PER_BEAT)

// Almost-full in the beat FIFO leaves room for beats already in flight
`define SUI_FIFO_DEPTH      8
`define SUI_FIFO_THRESHOLD  6

`endif

// File: design/sui_pkg.sv
// Beat types shared by the upstream serializer, the FIFO and the output pipe
`default_nettype none

`include "sui_params.svh"

package sui_pkg;

  // ----------------------------------------
  // Beat position within a message
  // ----------------------------------------
  typedef enum logic [1:0]
  {
    UP_CNTL_MOM = 2'd0,
    UP_CNTL_SOM = 2'd1,
    UP_CNTL_EOM = 2'd2
  } up_cntl_t;

  // Packet type that marks the first beat as data
  typedef enum logic [1:0]
  {
    UP_TYPE_NA   = 2'd0,
    UP_TYPE_DATA = 2'd1
  } up_type_t;

  // ----------------------------------------
  // One 44-bit bus beat
  // ----------------------------------------
  typedef struct packed
  {
    up_cntl_t                     cntl;
    up_type_t                     pkt_type;
    logic [`SUI_DATA_WIDTH-1:0]   data;
    // Tag travels out of band
    logic [`SUI_TAG_WIDTH-1:0]    oob_data;
  } up_beat_t;

endpackage

`default_nettype wire

// File: design/sync_fifo.sv
// Synchronous FIFO of any item type, with registered read data and almost-full
`timescale 1ns/1ps
`default_nettype none

`include "sui_params.svh"

module sync_fifo
#(
  parameter type item_t = logic [7:0],
  parameter int  depth  = 8
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  write,
  input  item_t write_item,
  input  logic  read,
  output item_t read_item,
  output logic  empty,
  output logic  almost_full
);

  localparam int PTR_W = $clog2(depth);
  localparam int CNT_W = $clog2(depth + 1);

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------
  item_t             mem [depth];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  // Fill level from 0 to depth
  logic [CNT_W-1:0]  count;
  logic              full;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Explicit wrap since depth need not be a power of two
      if (write)
        wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (read)
        rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous read and write leaves the level alone
      case ({write, read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Array write
  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= write_item;
  end

  // Item shows up on the output one cycle after read
  always_ff @(posedge clk)
  begin
    if (read)
      read_item <= mem[rd_ptr];
  end

  // ----------------------------------------
  // Status flags
  // ----------------------------------------
  assign empty       = (count == '0);
  assign full        = (count == CNT_W'(depth));
  assign almost_full = (count >= CNT_W'(`SUI_FIFO_THRESHOLD));

  // Producer must back off on almost-full well before the array fills
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) write |-> !full)
    else $error("FIFO written while full");

  // Consumer only reads what is there
  a_no_read_empty: assert property (@(posedge clk) disable iff (rst) read |-> !empty)
    else $error("FIFO read while empty");

endmodule

`default_nettype wire

// File: design/lane_serializer.sv
// Registers the SIMD lanes and tag, then writes them into the beat FIFO as four beats
`timescale 1ns/1ps
`default_nettype none

`include "sui_params.svh"

module lane_serializer
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`SUI_LANE_WIDTH-1:0]  regs [`SUI_NUM_LANES],
  input  logic [`SUI_NUM_LANES-1:0]   regs_valid,
  input  logic [`SUI_TAG_WIDTH-1:0]   tag,
  output logic                        regs_complete,
  input  logic                        almost_full,
  output logic                        write,
  output sui_pkg::up_beat_t           beat
);

  import sui_pkg::*;

  localparam int LW    = `SUI_LANE_WIDTH;
  localparam int LPB   = `SUI_LANES_PER_BEAT;
  localparam int CNT_W = $clog2(`SUI_NUM_BEATS);

  typedef enum logic [1:0]
  {
    ST_WAIT,
    ST_SEND,
    ST_COMPLETE
  } state_t;

  // ----------------------------------------
  // Input registers
  // ----------------------------------------
  logic [LW-1:0]              regs_d1 [`SUI_NUM_LANES];
  logic [`SUI_NUM_LANES-1:0]  regs_valid_d1;
  logic [`SUI_TAG_WIDTH-1:0]  tag_d1;
  logic                       all_valid;

  // Lane payload and tag
  always_ff @(posedge clk)
  begin
    regs_d1 <= regs;
    tag_d1  <= tag;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      regs_valid_d1 <= '0;
    else
      regs_valid_d1 <= regs_valid;
  end

  // Every lane has to be loaded before a transfer
  assign all_valid = &regs_valid_d1;

  // ----------------------------------------
  // Transfer controller
  // ----------------------------------------
  state_t            state;
  state_t            state_next;
  logic [CNT_W-1:0]  beat_cnt;
  logic              last_beat;

  assign last_beat = (beat_cnt == CNT_W'(`SUI_NUM_BEATS - 1));

  // One beat per cycle with almost-full pausing between beats
  assign write = (state == ST_SEND) && !almost_full;

  always_comb
  begin
    state_next = state;
    case (state)
      ST_WAIT:
        if (all_valid && !almost_full)
          state_next = ST_SEND;
      ST_SEND:
        if (write && last_beat)
          state_next = ST_COMPLETE;
      // Hold until the SIMD drops its valids
      ST_COMPLETE:
        if (!all_valid)
          state_next = ST_WAIT;
      default:
        state_next = ST_WAIT;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ST_WAIT;
      beat_cnt <= '0;
    end
    else
    begin
      state <= state_next;
      // Counter returns to zero after the end beat
      if (write)
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
    end
  end

  assign regs_complete = (state == ST_COMPLETE);

  // ----------------------------------------
  // Beat mux
  // ----------------------------------------
  always_comb
  begin : beat_mux
    int base;
    base = int'(beat_cnt) * LPB;
    // Lower lane in the low half
    for (int j = 0; j < LPB; j++)
      beat.data[j*LW +: LW] = regs_d1[base + j];
    if (beat_cnt == '0)
      beat.cntl = UP_CNTL_SOM;
    else if (last_beat)
      beat.cntl = UP_CNTL_EOM;
    else
      beat.cntl = UP_CNTL_MOM;
    beat.pkt_type = (beat_cnt == '0) ? UP_TYPE_DATA : UP_TYPE_NA;
    beat.oob_data = tag_d1;
  end

  // Nothing written while complete
  a_no_write_complete: assert property (@(posedge clk) disable iff (rst)
    regs_complete |-> !write)
    else $error("Beat written while complete");

endmodule

`default_nettype wire

// File: design/upstream_out_pipe.sv
// Two-stage pipe from the beat FIFO onto the stack upstream bus, under a registered ready
`timescale 1ns/1ps
`default_nettype none

module upstream_out_pipe
(
  input  logic               clk,
  input  logic               rst,
  input  logic               empty,
  output logic               read,
  input  sui_pkg::up_beat_t  read_item,
  input  logic               ready,
  output logic               up_valid,
  output sui_pkg::up_beat_t  up_beat
);

  import sui_pkg::*;

  // ----------------------------------------
  // Registered bus ready
  // ----------------------------------------
  logic ready_d1;

  always_ff @(posedge clk)
  begin
    if (rst)
      ready_d1 <= 1'b0;
    else
      ready_d1 <= ready;
  end

  // Stage 1 is the FIFO output register, stage 2 the bus register
  logic      fifo_pipe_valid;
  logic      fifo_pipe_read;
  logic      pipe_valid;
  logic      pipe_read;
  up_beat_t  pipe_beat;

  // Keep the pipe charged
  assign read           = !empty && (!fifo_pipe_valid || fifo_pipe_read);
  assign fifo_pipe_read = fifo_pipe_valid && (!pipe_valid || pipe_read);
  // Bus takes the beat when it was ready a cycle ago
  assign pipe_read      = ready_d1 && pipe_valid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fifo_pipe_valid <= 1'b0;
      pipe_valid      <= 1'b0;
    end
    else
    begin
      // A read refills stage 1 even as it drains
      if (read)
        fifo_pipe_valid <= 1'b1;
      else if (fifo_pipe_read)
        fifo_pipe_valid <= 1'b0;
      if (fifo_pipe_read)
        pipe_valid <= 1'b1;
      else if (pipe_read)
        pipe_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fifo_pipe_read)
      pipe_beat <= read_item;
  end

  assign up_valid = pipe_read;
  assign up_beat  = pipe_beat;

  // Bus sees valid only one cycle after its own ready
  a_valid_after_ready: assert property (@(posedge clk) disable iff (rst)
    up_valid |-> $past(ready))
    else $error("up_valid without ready one cycle earlier");

endmodule

`default_nettype wire

// File: design/simd_upstream_intf.sv
// Top of the upstream path from the SIMD lane registers to the stack upstream bus
`timescale 1ns/1ps
`default_nettype none

`include "sui_params.svh"

module simd_upstream_intf
(
  input  logic                        clk,
  input  logic                        rst,
  // SIMD side
  input  logic [`SUI_LANE_WIDTH-1:0]  regs [`SUI_NUM_LANES],
  input  logic [`SUI_NUM_LANES-1:0]   regs_valid,
  input  logic [`SUI_TAG_WIDTH-1:0]   tag,
  output logic                        regs_complete,
  // Stack upstream bus
  input  logic                        ready,
  output logic                        up_valid,
  output sui_pkg::up_cntl_t           up_cntl,
  output sui_pkg::up_type_t           up_type,
  output logic [`SUI_DATA_WIDTH-1:0]  up_data,
  output logic [`SUI_TAG_WIDTH-1:0]   up_oob_data
);

  import sui_pkg::*;

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------
  logic      fifo_write;
  up_beat_t  fifo_write_beat;
  logic      fifo_almost_full;
  logic      fifo_read;
  up_beat_t  fifo_read_beat;
  logic      fifo_empty;
  up_beat_t  up_beat;

  lane_serializer u_lane_serializer
  (
    .clk           (clk),
    .rst           (rst),
    .regs          (regs),
    .regs_valid    (regs_valid),
    .tag           (tag),
    .regs_complete (regs_complete),
    .almost_full   (fifo_almost_full),
    .write         (fifo_write),
    .beat          (fifo_write_beat)
  );

  // Beat FIFO between controller and output pipe
  sync_fifo #(.item_t(up_beat_t), .depth(`SUI_FIFO_DEPTH)) u_sync_fifo
  (
    .clk         (clk),
    .rst         (rst),
    .write       (fifo_write),
    .write_item  (fifo_write_beat),
    .read        (fifo_read),
    .read_item   (fifo_read_beat),
    .empty       (fifo_empty),
    .almost_full (fifo_almost_full)
  );

  upstream_out_pipe u_upstream_out_pipe
  (
    .clk       (clk),
    .rst       (rst),
    .empty     (fifo_empty),
    .read      (fifo_read),
    .read_item (fifo_read_beat),
    .ready     (ready),
    .up_valid  (up_valid),
    .up_beat   (up_beat)
  );

  // Beat fields out to the bus pins
  assign up_cntl     = up_beat.cntl;
  assign up_type     = up_beat.pkt_type;
  assign up_data     = up_beat.data;
  assign up_oob_data = up_beat.oob_data;

endmodule

`default_nettype wire

// File: testbench/sui_clock_gen.sv
// Clock of 20 ns period and a 5 cycle reset for the upstream testbench
`timescale 1ns/1ps
`default_nettype none

module sui_clock_gen
#(
  parameter int half_period  = 10,
  parameter int reset_cycles = 5
)
(
  output logic clk,
  output logic rst
);

  // Free running clock
  initial
  begin
    clk = 1'b0;
    forever
      #(half_period) clk = ~clk;
  end

  // Reset drops on a falling edge, clear of the DUT's sampling edge
  initial
  begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/sui_tb.sv
// Replays the case file into the SIMD upstream path and checks every bus beat
`timescale 1ns/1ps
`default_nettype none

`include "sui_params.svh"

module sui_tb;

  import sui_pkg::*;

  localparam int TIMEOUT = 400;
  localparam int NB      = `SUI_NUM_BEATS;
  localparam int LW      = `SUI_LANE_WIDTH;

  logic                        clk;
  logic                        rst;
  logic [LW-1:0]               regs [`SUI_NUM_LANES];
  logic [`SUI_NUM_LANES-1:0]   regs_valid;
  logic [`SUI_TAG_WIDTH-1:0]   tag;
  logic                        regs_complete;
  logic                        ready;
  logic                        up_valid;
  up_cntl_t                    up_cntl;
  up_type_t                    up_type;
  logic [`SUI_DATA_WIDTH-1:0]  up_data;
  logic [`SUI_TAG_WIDTH-1:0]   up_oob_data;

  // Ready mode 0 is always, 1 every other cycle and 2 random
  int                          ready_mode;
  logic                        ready_phase;
  integer                      seed;
  integer                      rnd;

  // Cases as read, and beats seen on the bus
  logic [`SUI_NUM_LANES*LW-1:0]  case_lanes [$];
  logic [`SUI_TAG_WIDTH-1:0]     case_tag [$];
  int                            case_mode [$];
  logic [`SUI_DATA_WIDTH-1:0]    exp_data [$];
  logic [`SUI_TAG_WIDTH-1:0]     exp_tag [$];
  up_beat_t                      got_beat [$];

  sui_clock_gen u_sui_clock_gen
  (
    .clk (clk),
    .rst (rst)
  );

  simd_upstream_intf u_simd_upstream_intf
  (
    .clk           (clk),
    .rst           (rst),
    .regs          (regs),
    .regs_valid    (regs_valid),
    .tag           (tag),
    .regs_complete (regs_complete),
    .ready         (ready),
    .up_valid      (up_valid),
    .up_cntl       (up_cntl),
    .up_type       (up_type),
    .up_data       (up_data),
    .up_oob_data   (up_oob_data)
  );

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("ERRORS FOUND");
    $fatal(1, "Timeout");
  endtask

  // ----------------------------------------
  // Bus side ready driver and beat monitor
  // ----------------------------------------
  initial
  begin
    ready       = 1'b0;
    ready_phase = 1'b0;
    forever
    begin
      @(negedge clk);
      if (rst)
        ready = 1'b0;
      else if (ready_mode == 0)
        ready = 1'b1;
      else if (ready_mode == 1)
      begin
        ready_phase = ~ready_phase;
        ready       = ready_phase;
      end
      else
      begin
        rnd   = $random(seed);
        ready = rnd[0];
      end
    end
  end

  // Valid at the falling edge means a transfer at the next rising edge
  always @(negedge clk)
  begin
    if (!rst && up_valid)
      got_beat.push_back({up_cntl, up_type, up_data, up_oob_data});
  end

  // ----------------------------------------
  // Case replay
  // ----------------------------------------
  initial
  begin
    int                          fd;
    int                          n;
    int                          cycles;
    string                       line;
    logic [`SUI_TAG_WIDTH-1:0]   t;
    logic [LW-1:0]               lane [`SUI_NUM_LANES];
    logic [`SUI_DATA_WIDTH-1:0]  word [NB];
    logic [`SUI_NUM_LANES*LW-1:0] flat;
    int                          mode;
    up_cntl_t                    cntl_exp;

    seed       = 29300;
    ready_mode = 0;
    regs_valid = '0;
    tag        = '0;
    for (int j = 0; j < `SUI_NUM_LANES; j++)
      regs[j] = '0;

    fd = $fopen("testbench/sui_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the case file");
      $display("ERRORS FOUND");
      $fatal(1, "Missing stimulus");
    end
    // Comment and blank lines scan as zero fields
    while ($fgets(line, fd) > 0)
    begin
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %h %h %h %h", t,
                  lane[0], lane[1], lane[2], lane[3], lane[4], lane[5], lane[6], lane[7],
                  mode, word[0], word[1], word[2], word[3]);
      if (n == 14)
      begin
        for (int j = 0; j < `SUI_NUM_LANES; j++)
          flat[j*LW +: LW] = lane[j];
        case_lanes.push_back(flat);
        case_tag.push_back(t);
        case_mode.push_back(mode);
        // Lane 2k low, lane 2k+1 high
        for (int k = 0; k < NB; k++)
        begin
          check_value($sformatf("case file packing %0d", k), {lane[2*k+1], lane[2*k]}, word[k]);
          exp_data.push_back(word[k]);
          exp_tag.push_back(t);
        end
      end
      else if (n > 0)
      begin
        $display("Malformed line in the case file");
        $display("ERRORS FOUND");
        $fatal(1, "Bad stimulus");
      end
    end
    $fclose(fd);

    cycles = 0;
    while (rst)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > 20)
        report_timeout("reset never released");
    end

    // Quiet bus while no lane is valid
    repeat (10)
    begin
      @(negedge clk);
      check_value("idle up_valid", 0, up_valid);
      check_value("idle regs_complete", 0, regs_complete);
    end

    for (int c = 0; c < case_tag.size(); c++)
    begin
      @(negedge clk);
      ready_mode = case_mode[c];
      tag        = case_tag[c];
      for (int j = 0; j < `SUI_NUM_LANES; j++)
        regs[j] = case_lanes[c][j*LW +: LW];
      regs_valid = '1;

      cycles = 0;
      while (!regs_complete)
      begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT)
          report_timeout("regs_complete never rose");
      end
      // Input register plus one cycle per beat at the least
      check_value($sformatf("case %0d complete latency", c), 1, cycles > NB);

      // Complete holds while the valids stay up
      repeat (3)
      begin
        @(negedge clk);
        check_value($sformatf("case %0d complete held", c), 1, regs_complete);
      end
      regs_valid = '0;
      // Scramble the lanes now that the SIMD is free
      for (int j = 0; j < `SUI_NUM_LANES; j++)
        regs[j] = ~regs[j];

      cycles = 0;
      while (regs_complete)
      begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT)
          report_timeout("regs_complete never fell");
      end
    end

    // ----------------------------------------
    // Drain and compare
    // ----------------------------------------
    cycles = 0;
    while (got_beat.size() < exp_data.size())
    begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        report_timeout("beats missing on the bus");
    end
    // Extra beats would show up here
    repeat (20) @(negedge clk);
    check_value("beat count", exp_data.size(), got_beat.size());

    for (int i = 0; i < got_beat.size(); i++)
    begin
      if (i % NB == 0)
        cntl_exp = UP_CNTL_SOM;
      else if (i % NB == NB - 1)
        cntl_exp = UP_CNTL_EOM;
      else
        cntl_exp = UP_CNTL_MOM;
      check_value($sformatf("beat %0d cntl", i), cntl_exp, got_beat[i].cntl);
      check_value($sformatf("beat %0d type", i), (i % NB == 0) ? UP_TYPE_DATA : UP_TYPE_NA,
                  got_beat[i].pkt_type);
      check_value($sformatf("beat %0d data", i), exp_data[i], got_beat[i].data);
      check_value($sformatf("beat %0d oob", i), exp_tag[i], got_beat[i].oob_data);
    end

    if (case_tag.size() == 0)
    begin
      $display("No cases found in the case file");
      $display("ERRORS FOUND");
      $fatal(1, "Empty stimulus");
    end
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: testbench/sui_cases.txt
# tag lane0 lane1 lane2 lane3 lane4 lane5 lane6 lane7 ready_mode beat0 beat1 beat2 beat3
# ready_mode 0 always, 1 every other cycle, 2 random; beatK = {lane 2K+1, lane 2K} in hex
11 0001 0002 0003 0004 0005 0006 0007 0008 0 00020001 00040003 00060005 00080007
a5 1234 5678 9abc def0 0f0f f0f0 aaaa 5555 0 56781234 def09abc f0f00f0f 5555aaaa
3c ffff 0000 8001 7ffe dead beef cafe f00d 1 0000ffff 7ffe8001 beefdead f00dcafe
00 0000 0000 0000 0000 0000 0000 0000 0000 1 00000000 00000000 00000000 00000000
ff 1111 2222 3333 4444 5555 6666 7777 8888 2 22221111 44443333 66665555 88887777
7e abcd ef01 2345 6789 0246 8ace 1357 9bdf 2 ef01abcd 67892345 8ace0246 9bdf1357
81 0100 0200 0300 0400 0500 0600 0700 0800 2 02000100 04000300 06000500 08000700
42 fedc ba98 7654 3210 0f1e 2d3c 4b5a 6978 1 ba98fedc 32107654 2d3c0f1e 69784b5a
c3 beef dead 0bad f00d 1234 4321 aaaa bbbb 2 deadbeef f00d0bad 43211234 bbbbaaaa
5a 8000 0001 c000 0003 e000 0007 f000 000f 0 00018000 0003c000 0007e000 000ff000

// File: filelist.f
+incdir+design
design/sui_pkg.sv
design/sync_fifo.sv
design/lane_serializer.sv
design/upstream_out_pipe.sv
design/simd_upstream_intf.sv
testbench/sui_clock_gen.sv
testbench/sui_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SIMD upstream testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module sui_tb \
  -f filelist.f \
  -o sui_sim

# A $fatal in the testbench gives a failing exit status
./obj_dir/sui_sim
